// ==== compile.f ====
+incdir+verilog
verilog/acq_types_pkg.sv
verilog/serial_pkg.sv
verilog/adc_sequencer.sv
verilog/sample_dispatcher.sv
verilog/serial_transmitter.sv
verilog/acq_link_top.sv
sim/acq_link_props.sv
sim/acq_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the acquisition link testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f compile.f --top-module acq_link_tb -Mdir obj_dir
status=0
./obj_dir/Vacq_link_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

// ==== sim/acq_link_props.sv ====
//////////////////////////////////////////////////////////////////////
// transmitter busy is rebuilt from byte_load and byte_done only
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

module acq_link_props (
	input wire                   clock,
	input wire                   rst_n,
	input wire                   byte_load,
	input wire                   byte_done,
	input wire                   soc,
	input wire                   load_dato,
	input wire [`ACQ_CHAN_W-1:0] canale,
	input wire                   data_out
);
	timeunit 1ns;
	timeprecision 100ps;

	logic tx_busy;

	// transmitter owns the line from byte_load to byte_done
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
		end else if (byte_load) begin
			tx_busy <= 1'b1;
		end else if (byte_done) begin
			tx_busy <= 1'b0;
		end
	end

	a_load_idle: assert property (@(posedge clock) disable iff (!rst_n) byte_load |-> !tx_busy)
		else $error("byte_load arrived while a frame was in progress");

	a_load_soc: assert property (@(posedge clock) disable iff (!rst_n) load_dato |-> soc)
		else $error("load_dato pulsed with soc low");

	a_chan_range: assert property (@(posedge clock) disable iff (!rst_n)
		canale < `ACQ_NUM_CHANNELS)
		else $error("canale left the channel range");

	// line idles high
	a_idle_high: assert property (@(posedge clock) disable iff (!rst_n) !tx_busy |-> data_out)
		else $error("data_out low while the transmitter is idle");

	a_done_load: assert property (@(posedge clock) disable iff (!rst_n) !(byte_done && byte_load))
		else $error("byte_done and byte_load in the same cycle");

endmodule

bind acq_link_top acq_link_props u_props (
	.clock     (clock),
	.rst_n     (rst_n),
	.byte_load (byte_load),
	.byte_done (byte_done),
	.soc       (soc),
	.load_dato (load_dato),
	.canale    (canale),
	.data_out  (data_out)
);

`default_nettype wire

// ==== sim/acq_link_tb.sv ====
//////////////////////////////////////////////////////////////////////
// samples and eoc busy times come from a 16-bit LFSR seeded with 3
// dsr only changes just after a soc, so a sample is all sent or all dropped
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

module acq_link_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// conversions in the run, dsr drops after REFUSE_AT and stays low for 3
	localparam int N_CONV    = 25;
	localparam int REFUSE_AT = 12;

	logic                    clock = 1'b0;
	logic                    rst_n;
	logic                    eoc;
	logic                    dsr;
	logic [7:0]              data_in;
	wire                     mux_en;
	wire                     soc;
	wire                     load_dato;
	wire                     add_mpx2;
	wire                     data_out;
	wire                     error;
	wire [`ACQ_CHAN_W-1:0]   canale;

	logic [15:0] lfsr = 16'd3;
	logic [15:0] sample = '0;
	// expected frames in line order, {add_mpx2, byte}
	logic [8:0]  exp_q[$];
	int          errors = 0;
	int          convs = 0;
	int          frames = 0;

	acq_link_top u_acq_link_top (.*);

	always #5 clock = ~clock;

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one LFSR step per bit taken, MSB drawn first
	task automatic draw(input int nbits, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[14:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERROR t=%0d ns %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic check_resets();
		check_val("soc", 16'd0, 16'(soc));
		check_val("load_dato", 16'd0, 16'(load_dato));
		check_val("add_mpx2", 16'd0, 16'(add_mpx2));
		check_val("error", 16'd0, 16'(error));
		check_val("data_out", 16'd1, 16'(data_out));
	endtask

	task automatic wait_convs(input int target);
		int n;
		n = 0;
		while (convs < target && n < 4000) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (convs < target) note_timeout("conversions to go on");
	endtask

	// latch output follows the half select
	initial begin : adc_latch
		data_in = '0;
		forever begin
			@(posedge clock);
			#1;
			data_in = add_mpx2 ? sample[7:0] : sample[15:8];
		end
	end

	// ADC model, one pass per conversion
	initial begin : adc_model
		logic [15:0] busy;
		int          n;
		eoc = 1'b1;
		forever begin
			n = 0;
			while (soc !== 1'b1 && n < 4000) begin
				@(posedge clock);
				#1;
				n++;
			end
			if (soc !== 1'b1) note_timeout("soc to rise");
			// channel counts up from 0 and wraps at the channel count
			check_val("canale", 16'(convs % `ACQ_NUM_CHANNELS), 16'(canale));
			convs++;
			draw(16, sample);
			draw(3, busy);
			repeat (busy + 1) @(posedge clock);
			#1;
			eoc = 1'b0;
			n = 0;
			while (soc !== 1'b0 && n < 50) begin
				@(posedge clock);
				#1;
				n++;
			end
			if (soc !== 1'b0) note_timeout("soc to fall");
			eoc = 1'b1;
			// dsr is stable from here until both byte loads
			if (dsr) begin
				exp_q.push_back({1'b0, sample[15:8]});
				exp_q.push_back({1'b1, sample[7:0]});
			end
		end
	end

	// line decoder, samples each bit in its middle
	initial begin : line_decoder
		logic [7:0] rx;
		logic [8:0] exp;
		logic       half;
		logic       prev;
		int         n;
		rx = '0;
		forever begin
			n = 0;
			do begin
				prev = data_out;
				@(posedge clock);
				#1;
				n++;
			end while (!(prev === 1'b1 && data_out === 1'b0) && n < 20000);
			if (data_out !== 1'b0) note_timeout("a start bit");
			half = add_mpx2;
			repeat (`ACQ_BIT_PERIOD / 2) @(posedge clock);
			#1;
			check_val("start bit", 16'd0, 16'(data_out));
			for (int i = 0; i < 8; i++) begin
				repeat (`ACQ_BIT_PERIOD) @(posedge clock);
				#1;
				rx = {rx[6:0], data_out};
			end
			repeat (`ACQ_BIT_PERIOD) @(posedge clock);
			#1;
			check_val("stop bit", 16'd1, 16'(data_out));
			frames++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("a frame appeared on the line with no sample waiting to be sent");
			end else begin
				exp = exp_q.pop_front();
				check_val("data_out byte", 16'(exp[7:0]), 16'(rx));
				check_val("add_mpx2", 16'(exp[8]), 16'(half));
			end
		end
	end

	initial begin : main
		int n;
		rst_n = 1'b0;
		dsr   = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		check_resets();
		repeat (4) @(posedge clock);
		#1;
		rst_n = 1'b1;
		check_resets();
		// first cycle out of reset selects the multiplexer
		@(posedge clock);
		#1;
		check_resets();
		check_val("mux_en", 16'd1, 16'(mux_en));

		wait_convs(REFUSE_AT);
		@(posedge clock);
		#1;
		dsr = 1'b0;
		wait_convs(REFUSE_AT + 3);
		check_val("error", 16'd1, 16'(error));
		@(posedge clock);
		#1;
		dsr = 1'b1;

		// error clears on the edge that starts the first accepted frame
		n = 0;
		while (error !== 1'b0 && n < 2000) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (error !== 1'b0) note_timeout("error to clear");
		check_val("data_out", 16'd0, 16'(data_out));

		// conversion N_CONV-1 has started, all before it are on the line
		wait_convs(N_CONV);
		check_val("frame count", 16'(2 * (N_CONV - 1 - 3)), 16'(frames));
		check_val("frames pending", 16'd0, 16'(exp_q.size()));

		$display("run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/acq_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// build-time constants for the acquisition link, no runtime config
// the baud counter must be wide enough to hold ACQ_BIT_PERIOD - 1
//////////////////////////////////////////////////////////////////////
`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// clock cycles per serial bit on data_out
`define ACQ_BIT_PERIOD 16

// width of the baud counter in the transmitter
`define ACQ_BIT_CNT_W 5

// channels behind the external multiplexer, canale wraps here
`define ACQ_NUM_CHANNELS 8

// width of the canale port
`define ACQ_CHAN_W 4

`endif

// ==== verilog/acq_link_top.sv ====
//////////////////////////////////////////////////////////////////////
// sequencer feeds dispatcher feeds transmitter, waits give backpressure
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

module acq_link_top (
	input  wire                     clock,
	input  wire                     rst_n,
	output wire                     mux_en,
	output wire                     soc,
	output wire                     load_dato,
	output wire [`ACQ_CHAN_W-1:0]   canale,
	output wire                     add_mpx2,
	input  wire                     eoc,
	input  wire [7:0]               data_in,
	output wire                     data_out,
	output wire                     error,
	input  wire                     dsr
);

	// sequencer to dispatcher
	wire sample_valid;
	wire sample_taken;

	// dispatcher to transmitter
	wire byte_load;
	wire byte_done;

	adc_sequencer u_sequencer (
		.clock        (clock),
		.rst_n        (rst_n),
		.eoc          (eoc),
		.sample_taken (sample_taken),
		.mux_en       (mux_en),
		.soc          (soc),
		.load_dato    (load_dato),
		.canale       (canale),
		.sample_valid (sample_valid)
	);

	sample_dispatcher u_dispatcher (
		.clock        (clock),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.byte_done    (byte_done),
		.sample_taken (sample_taken),
		.byte_load    (byte_load),
		.add_mpx2     (add_mpx2)
	);

	serial_transmitter u_transmitter (
		.clock     (clock),
		.rst_n     (rst_n),
		.byte_load (byte_load),
		.data_in   (data_in),
		.dsr       (dsr),
		.byte_done (byte_done),
		.data_out  (data_out),
		.error     (error)
	);

endmodule

`default_nettype wire

// ==== verilog/acq_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// state encodings for the sequencer and the sample dispatcher
//////////////////////////////////////////////////////////////////////
`default_nettype none

package acq_types_pkg;

	// conversion sequencer, one pass per sample
	typedef enum logic [2:0] {
		SELECT,
		SETTLE,
		START,
		WAIT_EOC,
		LOAD,
		ADVANCE,
		READY
	} seq_state_t;

	// dispatcher, two byte transfers per sample
	typedef enum logic [1:0] {
		WAIT_SAMPLE,
		SEND_BYTE,
		WAIT_END,
		TAKEN
	} dispatch_state_t;

endpackage

`default_nettype wire

// ==== verilog/adc_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// eoc is active low and sampled from the first cycle soc is high
// no new conversion starts until the dispatcher takes the sample
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

module adc_sequencer
	import acq_types_pkg::*;
(
	input  wire                     clock,
	input  wire                     rst_n,
	input  wire                     eoc,
	input  wire                     sample_taken,
	output logic                    mux_en,
	output logic                    soc,
	output logic                    load_dato,
	output logic [`ACQ_CHAN_W-1:0]  canale,
	output logic                    sample_valid
);

	seq_state_t state;
	logic       chan_last;

	// last multiplexer channel, the counter wraps to 0 after it
	assign chan_last = (canale == `ACQ_CHAN_W'(`ACQ_NUM_CHANNELS - 1));

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state        <= SELECT;
			mux_en       <= 1'b0;
			soc          <= 1'b0;
			load_dato    <= 1'b0;
			canale       <= '0;
			sample_valid <= 1'b0;
		end else begin
			case (state)
				// enable the multiplexer on the current channel
				SELECT: begin
					mux_en <= 1'b1;
					state  <= SETTLE;
				end
				// one cycle for the analog path to settle
				SETTLE: begin
					state <= START;
				end
				START: begin
					soc   <= 1'b1;
					state <= WAIT_EOC;
				end
				// conversion time set by the ADC, eoc low means done
				WAIT_EOC: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= LOAD;
					end
				end
				// latch strobe ends, channel moves on for the next pass
				LOAD: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					canale    <= chan_last ? '0 : canale + 1'b1;
					state     <= ADVANCE;
				end
				ADVANCE: begin
					sample_valid <= 1'b1;
					state        <= READY;
				end
				// hold the sample until the dispatcher releases it,
				// then reselect the multiplexer right away
				READY: begin
					if (sample_taken) begin
						sample_valid <= 1'b0;
						mux_en       <= 1'b1;
						state        <= SETTLE;
					end
				end
				default: begin
					state <= SELECT;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sample_dispatcher.sv ====
//////////////////////////////////////////////////////////////////////
// high byte goes first, add_mpx2 picks the half on the ADC latch
//////////////////////////////////////////////////////////////////////
`default_nettype none

module sample_dispatcher
	import acq_types_pkg::*;
(
	input  wire   clock,
	input  wire   rst_n,
	input  wire   sample_valid,
	input  wire   byte_done,
	output logic  sample_taken,
	output logic  byte_load,
	output logic  add_mpx2
);

	dispatch_state_t state;

	// add_mpx2 doubles as the half-select register
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state        <= WAIT_SAMPLE;
			sample_taken <= 1'b0;
			byte_load    <= 1'b0;
			add_mpx2     <= 1'b0;
		end else begin
			case (state)
				WAIT_SAMPLE: begin
					if (sample_valid) begin
						state <= SEND_BYTE;
					end
				end
				// add_mpx2 is already stable here
				SEND_BYTE: begin
					byte_load <= 1'b1;
					state     <= WAIT_END;
				end
				// byte_done ends the transfer, sent or refused alike
				WAIT_END: begin
					byte_load <= 1'b0;
					if (byte_done) begin
						if (!add_mpx2) begin
							add_mpx2 <= 1'b1;
							state    <= SEND_BYTE;
						end else begin
							add_mpx2     <= 1'b0;
							sample_taken <= 1'b1;
							state        <= TAKEN;
						end
					end
				end
				// sequencer drops sample_valid on the next edge
				TAKEN: begin
					sample_taken <= 1'b0;
					state        <= WAIT_SAMPLE;
				end
				default: begin
					state <= WAIT_SAMPLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/serial_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// transmitter state and frame slot, 10 slots per frame
//////////////////////////////////////////////////////////////////////
`default_nettype none

package serial_pkg;

	typedef enum logic [1:0] {IDLE, FRAME, REFUSE} tx_state_t;

	// slot order is the order on the line, data goes MSB first
	typedef enum logic [3:0] {
		START_BIT,
		BIT0, BIT1, BIT2, BIT3,
		BIT4, BIT5, BIT6, BIT7,
		STOP_BIT
	} bit_slot_t;

endpackage

`default_nettype wire

// ==== verilog/serial_transmitter.sv ====
//////////////////////////////////////////////////////////////////////
// byte_load is only legal while idle, the sender waits for byte_done
// a byte offered with dsr low is dropped and flags error
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "acq_cfg.svh"

module serial_transmitter
	import serial_pkg::*;
(
	input  wire        clock,
	input  wire        rst_n,
	input  wire        byte_load,
	input  wire  [7:0] data_in,
	input  wire        dsr,
	output logic       byte_done,
	output logic       data_out,
	output logic       error
);

	tx_state_t                 state;
	bit_slot_t                 slot;
	logic [`ACQ_BIT_CNT_W-1:0] baud_cnt;
	logic                      bit_end;
	logic                      data_slot;

	// transmit buffer, shifted left so bit 7 is always on the line
	logic [7:0]                tx_buf;

	assign bit_end   = (baud_cnt == `ACQ_BIT_CNT_W'(`ACQ_BIT_PERIOD - 1));
	assign data_slot = (slot != START_BIT) && (slot != STOP_BIT);

	// last stop-bit cycle or the cycle after a refusal
	assign byte_done = ((state == FRAME) && (slot == STOP_BIT) && bit_end)
		|| (state == REFUSE);

	// line idles high, start bit low, stop bit high
	always_comb begin
		data_out = 1'b1;
		if (state == FRAME) begin
			if (slot == START_BIT) begin
				data_out = 1'b0;
			end else if (data_slot) begin
				data_out = tx_buf[7];
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			slot     <= START_BIT;
			baud_cnt <= '0;
			error    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (byte_load) begin
						if (dsr) begin
							error    <= 1'b0;
							slot     <= START_BIT;
							baud_cnt <= '0;
							state    <= FRAME;
						end else begin
							error <= 1'b1;
							state <= REFUSE;
						end
					end
				end
				// buffer counts as full for the whole frame
				FRAME: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (slot == STOP_BIT) begin
							state <= IDLE;
						end else begin
							slot <= bit_slot_t'(slot + 1'b1);
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				REFUSE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// payload path, no reset
	always_ff @(posedge clock) begin
		if ((state == IDLE) && byte_load && dsr) begin
			tx_buf <= data_in;
		end else if ((state == FRAME) && data_slot && bit_end) begin
			tx_buf <= {tx_buf[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire
